//--- include/alu_config.svh
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// datapath width in bits
`define ALU_XLEN 32

// major opcodes accepted by the decoder
`define ALU_OPC_OP     7'b0110011
`define ALU_OPC_OP_IMM 7'b0010011
`define ALU_OPC_BRANCH 7'b1100011

`endif

//--- hw/alu_pkg.sv
`include "alu_config.svh"

package alu_pkg;

  // alu operations, rv32i base group then m extension
  typedef enum logic [4:0] {
    op_add,
    op_sub,
    op_sll,
    op_slt,
    op_sltu,
    op_xor,
    op_srl,
    op_sra,
    op_or,
    op_and,
    op_mul,
    op_mulh,
    op_mulhsu,
    op_mulhu,
    op_div,
    op_divu,
    op_rem,
    op_remu
  } alu_op_t;

  // branch compare kinds, none for non-branch instructions
  typedef enum logic [2:0] {
    cond_none,
    cond_eq,
    cond_ne,
    cond_lt,
    cond_ge,
    cond_ltu,
    cond_geu
  } branch_cond_t;

  typedef struct packed {
    logic zero;
    logic negative;
    logic carry_out;
    logic overflow;
  } alu_flags_t;

  // decode to execute
  typedef struct packed {
    alu_op_t               op;
    branch_cond_t          cond;
    logic [4:0]            rd;
    logic                  we;
    logic                  illegal;
    logic [`ALU_XLEN-1:0]  a;
    logic [`ALU_XLEN-1:0]  b;
  } decoded_t;

  // execute to result
  typedef struct packed {
    logic [`ALU_XLEN-1:0]  result;
    alu_flags_t            flags;
    branch_cond_t          cond;
    logic [4:0]            rd;
    logic                  we;
    logic                  illegal;
  } executed_t;

endpackage

//--- hw/prefix_adder.sv
`timescale 1ns/1ps

module prefix_adder #(
  parameter int WIDTH = 32
) (
  input  logic [WIDTH-1:0] a,
  input  logic [WIDTH-1:0] b,
  input  logic             carry_in,
  output logic [WIDTH-1:0] sum,
  output logic             carry_out
);

  localparam int LEVELS = $clog2(WIDTH);

  // group generate per level, gen[LEVELS][i] is the carry out of bit i
  wire [WIDTH-1:0] gen [LEVELS+1];
  // group propagate, not needed after the last level
  wire [WIDTH-1:0] prop [LEVELS];

  // carry in folded into bit 0 generate
  assign gen[0]  = (a & b) | {{(WIDTH-1){1'b0}}, (a[0] ^ b[0]) & carry_in};
  assign prop[0] = a ^ b;

  for (genvar l = 0; l < LEVELS; l++) begin : g_level
    for (genvar i = 0; i < WIDTH; i++) begin : g_bit
      if (((i >> l) & 1) == 1) begin : g_combine
        // top bit of the lower half of this block
        localparam int J = ((i >> l) << l) - 1;
        assign gen[l+1][i] = gen[l][i] | (prop[l][i] & gen[l][J]);
        if (l < LEVELS - 1) begin : g_prop
          assign prop[l+1][i] = prop[l][i] & prop[l][J];
        end
      end else begin : g_pass
        assign gen[l+1][i] = gen[l][i];
        if (l < LEVELS - 1) begin : g_prop
          assign prop[l+1][i] = prop[l][i];
        end
      end
    end
  end

  assign sum       = prop[0] ^ {gen[LEVELS][WIDTH-2:0], carry_in};
  assign carry_out = gen[LEVELS][WIDTH-1];

endmodule

//--- hw/barrel_shifter.sv
`timescale 1ns/1ps

module barrel_shifter #(
  parameter int WIDTH = 32
) (
  input  logic [WIDTH-1:0]         data,
  input  logic [$clog2(WIDTH)-1:0] shamt,
  input  logic                     left,
  input  logic                     arithmetic,
  output logic [WIDTH-1:0]         shifted
);

  localparam int SHW = $clog2(WIDTH);

  wire [WIDTH-1:0] data_rev;
  wire [WIDTH-1:0] out_rev;
  wire [WIDTH-1:0] layer [SHW+1];
  wire             fill;

  // left shift done as a right shift on the bit-reversed word
  for (genvar i = 0; i < WIDTH; i++) begin : g_rev
    assign data_rev[i] = data[WIDTH-1-i];
    assign out_rev[i]  = layer[SHW][WIDTH-1-i];
  end

  assign fill     = arithmetic & ~left & data[WIDTH-1];
  assign layer[0] = left ? data_rev : data;

  // one layer per shamt bit
  for (genvar k = 0; k < SHW; k++) begin : g_layer
    localparam int STEP = 1 << k;
    assign layer[k+1] = shamt[k] ? {{STEP{fill}}, layer[k][WIDTH-1:STEP]} : layer[k];
  end

  assign shifted = left ? out_rev : layer[SHW];

endmodule

//--- hw/alu_decoder.sv
`timescale 1ns/1ps
`include "alu_config.svh"

module alu_decoder (
  input  logic                 clock,
  input  logic                 arst_n,
  input  logic                 in_valid,
  input  logic [31:0]          instr,
  input  logic [`ALU_XLEN-1:0] rs1_data,
  input  logic [`ALU_XLEN-1:0] rs2_data,
  output logic                 dec_valid,
  output alu_pkg::decoded_t    dec
);
  import alu_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [`ALU_XLEN-1:0] imm_i;
  decoded_t next;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign imm_i  = {{(`ALU_XLEN-12){instr[31]}}, instr[31:20]};

  // funct3 selects the same base op for register and immediate forms
  function automatic alu_op_t base_op(input logic [2:0] f3);
    case (f3)
      3'b000: return op_add;
      3'b001: return op_sll;
      3'b010: return op_slt;
      3'b011: return op_sltu;
      3'b100: return op_xor;
      3'b101: return op_srl;
      3'b110: return op_or;
      default: return op_and;
    endcase
  endfunction

  always_comb begin
    next         = '0;
    next.op      = op_add;
    next.cond    = cond_none;
    next.rd      = instr[11:7];
    next.a       = rs1_data;
    next.b       = rs2_data;
    case (opcode)
      `ALU_OPC_OP: begin
        if (funct7 == 7'b0000000) begin
          next.op = base_op(funct3);
        end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
          next.op = op_sub;
        end else if (funct7 == 7'b0100000 && funct3 == 3'b101) begin
          next.op = op_sra;
        end else if (funct7 == 7'b0000001) begin
          // m group follows funct3 in enum order
          next.op = alu_op_t'(5'(op_mul) + 5'(funct3));
        end else begin
          next.illegal = 1'b1;
        end
      end
      `ALU_OPC_OP_IMM: begin
        next.b  = imm_i;
        next.op = base_op(funct3);
        if (funct3 == 3'b001 && funct7 != 7'b0000000) begin
          next.illegal = 1'b1;
        end else if (funct3 == 3'b101) begin
          next.illegal = (funct7 & 7'b1011111) != 7'b0000000;
          if (funct7[5]) begin
            next.op = op_sra;
          end
        end
      end
      `ALU_OPC_BRANCH: begin
        next.op = op_sub;
        case (funct3)
          3'b000: next.cond = cond_eq;
          3'b001: next.cond = cond_ne;
          3'b100: next.cond = cond_lt;
          3'b101: next.cond = cond_ge;
          3'b110: next.cond = cond_ltu;
          3'b111: next.cond = cond_geu;
          default: next.illegal = 1'b1;
        endcase
      end
      default: next.illegal = 1'b1;
    endcase
    // branches, illegal encodings and x0 never write
    next.we = !next.illegal && next.rd != 5'd0 && opcode != `ALU_OPC_BRANCH;
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= in_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (in_valid) begin
      dec <= next;
    end
  end

endmodule

//--- hw/alu_execute.sv
`timescale 1ns/1ps
`include "alu_config.svh"

module alu_execute (
  input  logic               clock,
  input  logic               arst_n,
  input  logic               dec_valid,
  input  alu_pkg::decoded_t  dec,
  output logic               ex_valid,
  output alu_pkg::executed_t ex
);
  import alu_pkg::*;

  localparam int XLEN = `ALU_XLEN;
  localparam int SHW  = $clog2(XLEN);

  logic [XLEN-1:0]          a;
  logic [XLEN-1:0]          b;
  logic                     use_sub;
  logic [XLEN-1:0]          sum;
  logic                     carry;
  logic [XLEN-1:0]          shifted;
  alu_flags_t               flags;
  logic [2*XLEN-1:0]        prod_uu;
  logic signed [2*XLEN-1:0] prod_ss;
  logic signed [2*XLEN+1:0] prod_su;
  logic                     div_zero;
  logic                     div_ovf;
  logic signed [XLEN-1:0]   quo_s;
  logic signed [XLEN-1:0]   rem_s;
  logic [XLEN-1:0]          res;

  assign a = dec.a;
  assign b = dec.b;

  // compares and branches run through the subtractor
  assign use_sub = dec.op == op_sub || dec.op == op_slt || dec.op == op_sltu ||
                   dec.cond != cond_none;

  prefix_adder #(
    .WIDTH(XLEN)
  ) adder_i (
    .a        (a),
    .b        (b ^ {XLEN{use_sub}}),
    .carry_in (use_sub),
    .sum      (sum),
    .carry_out(carry)
  );

  barrel_shifter #(
    .WIDTH(XLEN)
  ) shifter_i (
    .data      (a),
    .shamt     (b[SHW-1:0]),
    .left      (dec.op == op_sll),
    .arithmetic(dec.op == op_sra),
    .shifted   (shifted)
  );

  // flags always reflect the adder
  assign flags.zero      = sum == '0;
  assign flags.negative  = sum[XLEN-1];
  assign flags.carry_out = carry;
  assign flags.overflow  = ~(a[XLEN-1] ^ b[XLEN-1] ^ use_sub) & (a[XLEN-1] ^ sum[XLEN-1]);

  // full products for the high-half ops
  assign prod_uu = a * b;
  assign prod_ss = $signed(a) * $signed(b);
  assign prod_su = $signed({a[XLEN-1], a}) * $signed({1'b0, b});

  // riscv division corner cases
  assign div_zero = b == '0;
  assign div_ovf  = a == {1'b1, {(XLEN-1){1'b0}}} && b == '1;

  // signed quotient and remainder, corner cases picked in the case below
  assign quo_s = $signed(a) / $signed(b);
  assign rem_s = $signed(a) % $signed(b);

  always_comb begin
    case (dec.op)
      op_sll:    res = shifted;
      op_srl:    res = shifted;
      op_sra:    res = shifted;
      op_slt:    res = {{(XLEN-1){1'b0}}, flags.negative ^ flags.overflow};
      op_sltu:   res = {{(XLEN-1){1'b0}}, ~carry};
      op_xor:    res = a ^ b;
      op_or:     res = a | b;
      op_and:    res = a & b;
      op_mul:    res = prod_uu[XLEN-1:0];
      op_mulh:   res = prod_ss[2*XLEN-1:XLEN];
      op_mulhsu: res = prod_su[2*XLEN-1:XLEN];
      op_mulhu:  res = prod_uu[2*XLEN-1:XLEN];
      op_div:    res = div_zero ? '1 : div_ovf ? a : quo_s;
      op_divu:   res = div_zero ? '1 : a / b;
      op_rem:    res = div_zero ? a : div_ovf ? '0 : rem_s;
      op_remu:   res = div_zero ? a : a % b;
      // add and sub
      default:   res = sum;
    endcase
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      ex_valid <= 1'b0;
    end else begin
      ex_valid <= dec_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (dec_valid) begin
      ex.result  <= res;
      ex.flags   <= flags;
      ex.cond    <= dec.cond;
      ex.rd      <= dec.rd;
      ex.we      <= dec.we;
      ex.illegal <= dec.illegal;
    end
  end

endmodule

//--- hw/alu_result.sv
`timescale 1ns/1ps
`include "alu_config.svh"

module alu_result (
  input  logic                 clock,
  input  logic                 arst_n,
  input  logic                 ex_valid,
  input  alu_pkg::executed_t   ex,
  output logic                 out_valid,
  output logic [`ALU_XLEN-1:0] result,
  output logic [4:0]           rd,
  output logic                 write_en,
  output alu_pkg::alu_flags_t  flags,
  output logic                 branch_taken,
  output logic                 illegal
);
  import alu_pkg::*;

  logic lt;
  logic take;

  // signed less-than from the subtract flags
  assign lt = ex.flags.negative ^ ex.flags.overflow;

  always_comb begin
    case (ex.cond)
      cond_eq:  take = ex.flags.zero;
      cond_ne:  take = ~ex.flags.zero;
      cond_lt:  take = lt;
      cond_ge:  take = ~lt;
      cond_ltu: take = ~ex.flags.carry_out;
      cond_geu: take = ex.flags.carry_out;
      default:  take = 1'b0;
    endcase
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      out_valid    <= 1'b0;
      write_en     <= 1'b0;
      branch_taken <= 1'b0;
      illegal      <= 1'b0;
    end else begin
      out_valid    <= ex_valid;
      write_en     <= ex_valid & ex.we;
      branch_taken <= ex_valid & take;
      if (ex_valid) begin
        illegal <= ex.illegal;
      end
    end
  end

  // result data holds between instructions
  always_ff @(posedge clock) begin
    if (ex_valid) begin
      result <= ex.result;
      rd     <= ex.rd;
      flags  <= ex.flags;
    end
  end

endmodule

//--- hw/alu_top.sv
`timescale 1ns/1ps
`include "alu_config.svh"

module alu_top (
  input  logic                 clock,
  input  logic                 arst_n,
  input  logic                 in_valid,
  input  logic [31:0]          instr,
  input  logic [`ALU_XLEN-1:0] rs1_data,
  input  logic [`ALU_XLEN-1:0] rs2_data,
  output logic                 out_valid,
  output logic [`ALU_XLEN-1:0] result,
  output logic [4:0]           rd,
  output logic                 write_en,
  output alu_pkg::alu_flags_t  flags,
  output logic                 branch_taken,
  output logic                 illegal
);
  import alu_pkg::*;

  logic      dec_valid;
  decoded_t  dec;
  logic      ex_valid;
  executed_t ex;

  // decode, execute, result, one cycle each
  alu_decoder alu_decoder_i (
    .clock    (clock),
    .arst_n   (arst_n),
    .in_valid (in_valid),
    .instr    (instr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .dec_valid(dec_valid),
    .dec      (dec)
  );

  alu_execute alu_execute_i (
    .clock    (clock),
    .arst_n   (arst_n),
    .dec_valid(dec_valid),
    .dec      (dec),
    .ex_valid (ex_valid),
    .ex       (ex)
  );

  alu_result alu_result_i (
    .clock       (clock),
    .arst_n      (arst_n),
    .ex_valid    (ex_valid),
    .ex          (ex),
    .out_valid   (out_valid),
    .result      (result),
    .rd          (rd),
    .write_en    (write_en),
    .flags       (flags),
    .branch_taken(branch_taken),
    .illegal     (illegal)
  );

endmodule

//--- bench/alu_properties.sv
`timescale 1ns/1ps

module alu_properties (
  input logic clock,
  input logic arst_n,
  input logic in_valid,
  input logic out_valid,
  input logic write_en,
  input logic branch_taken,
  input logic illegal
);

  int failures = 0;

  // three register stages between in_valid and out_valid
  a_latency: assert property (@(posedge clock) disable iff (!arst_n)
    in_valid |-> ##3 out_valid)
  else begin
    failures++;
    $error("out_valid missing three cycles after in_valid");
  end

  a_no_extra: assert property (@(posedge clock) disable iff (!arst_n)
    !in_valid |-> ##3 !out_valid)
  else begin
    failures++;
    $error("out_valid without an instruction three cycles earlier");
  end

  a_we_valid: assert property (@(posedge clock) disable iff (!arst_n)
    write_en |-> out_valid)
  else begin
    failures++;
    $error("write_en high while out_valid is low");
  end

  a_taken_valid: assert property (@(posedge clock) disable iff (!arst_n)
    branch_taken |-> out_valid)
  else begin
    failures++;
    $error("branch_taken high while out_valid is low");
  end

  // an illegal instruction never writes the register file
  a_illegal_no_we: assert property (@(posedge clock) disable iff (!arst_n)
    illegal |-> !write_en)
  else begin
    failures++;
    $error("write_en high for an illegal instruction");
  end

endmodule

bind alu_top alu_properties alu_properties_i (.*);

//--- bench/alu_checker.sv
`timescale 1ns/1ps
`include "alu_config.svh"

module alu_checker (
  input  logic                 clock,
  input  logic                 arst_n,
  input  logic                 in_valid,
  input  logic [31:0]          instr,
  input  logic [`ALU_XLEN-1:0] rs1_data,
  input  logic [`ALU_XLEN-1:0] rs2_data,
  input  logic                 out_valid,
  input  logic [`ALU_XLEN-1:0] result,
  input  logic [4:0]           rd,
  input  logic                 write_en,
  input  alu_pkg::alu_flags_t  flags,
  input  logic                 branch_taken,
  input  logic                 illegal,
  output int                   checked,
  output int                   errors,
  output int                   pending
);
  import alu_pkg::*;

  localparam int XLEN = `ALU_XLEN;

  typedef struct packed {
    logic [31:0]     instr;
    logic [XLEN-1:0] result;
    alu_flags_t      flags;
    logic [4:0]      rd;
    logic            we;
    logic            taken;
    logic            illegal;
    logic [31:0]     due;
  } expect_t;

  expect_t exp_q[$];
  int      cycle;

  // expected outputs straight from the instruction encoding
  function automatic expect_t predict(input logic [31:0] ins, input logic [XLEN-1:0] a,
                                      input logic [XLEN-1:0] rs2);
    expect_t                e;
    logic [6:0]             opc;
    logic [2:0]             f3;
    logic [6:0]             f7;
    logic [XLEN-1:0]        b;
    logic signed [XLEN-1:0] sa;
    logic signed [XLEN-1:0] sb;
    logic [4:0]             sh;
    logic                   legal;
    logic                   sub_mode;
    logic [XLEN:0]          wide;
    logic [2*XLEN-1:0]      prod;
    logic signed [XLEN-1:0] quo;
    logic signed [XLEN-1:0] rem;
    opc = ins[6:0];
    f3  = ins[14:12];
    f7  = ins[31:25];
    b   = (opc == `ALU_OPC_OP_IMM) ? {{(XLEN-12){ins[31]}}, ins[31:20]} : rs2;
    sa  = a;
    sb  = b;
    sh  = b[4:0];
    e   = '0;
    e.instr = ins;
    e.rd    = ins[11:7];
    case (opc)
      `ALU_OPC_OP: begin
        legal = f7 == 7'h00 || f7 == 7'h01 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
      end
      `ALU_OPC_OP_IMM: begin
        legal = f3 == 3'd1 ? f7 == 7'h00 : f3 == 3'd5 ? (f7 == 7'h00 || f7 == 7'h20) : 1'b1;
      end
      `ALU_OPC_BRANCH: legal = f3 != 3'd2 && f3 != 3'd3;
      default:         legal = 1'b0;
    endcase
    // sub, set-less-than and branches all compute a - b
    sub_mode = opc == `ALU_OPC_BRANCH || (opc == `ALU_OPC_OP && f7 == 7'h20 && f3 == 3'd0) ||
               ((opc == `ALU_OPC_OP_IMM || (opc == `ALU_OPC_OP && f7 == 7'h00)) &&
                (f3 == 3'd2 || f3 == 3'd3));
    wide = {1'b0, a} + {1'b0, sub_mode ? ~b : b} + sub_mode;
    e.flags.zero      = wide[XLEN-1:0] == '0;
    e.flags.negative  = wide[XLEN-1];
    e.flags.carry_out = wide[XLEN];
    e.flags.overflow  = (a[XLEN-1] == (b[XLEN-1] ^ sub_mode)) && (wide[XLEN-1] != a[XLEN-1]);
    // operands extended per signedness, low half of the product is exact
    prod = {{XLEN{a[XLEN-1] & (f3 != 3'd3)}}, a} * {{XLEN{b[XLEN-1] & (f3 < 3'd2)}}, b};
    if (b == '0) begin
      quo = -1;
      rem = sa;
    end else if (a == {1'b1, {(XLEN-1){1'b0}}} && b == '1) begin
      quo = sa;
      rem = 0;
    end else begin
      quo = sa / sb;
      rem = sa % sb;
    end
    if (opc == `ALU_OPC_OP && f7 == 7'h01) begin
      case (f3)
        3'd0:    e.result = prod[XLEN-1:0];
        3'd4:    e.result = quo;
        3'd5:    e.result = (b == '0) ? '1 : a / b;
        3'd6:    e.result = rem;
        3'd7:    e.result = (b == '0) ? a : a % b;
        default: e.result = prod[2*XLEN-1:XLEN];
      endcase
    end else if (opc == `ALU_OPC_BRANCH) begin
      e.result = a - b;
      case (f3)
        3'd0:    e.taken = a == b;
        3'd1:    e.taken = a != b;
        3'd4:    e.taken = sa < sb;
        3'd5:    e.taken = sa >= sb;
        3'd6:    e.taken = a < b;
        default: e.taken = a >= b;
      endcase
    end else begin
      case (f3)
        3'd0:    e.result = (opc == `ALU_OPC_OP && f7 == 7'h20) ? a - b : a + b;
        3'd1:    e.result = a << sh;
        3'd2:    e.result = XLEN'(sa < sb);
        3'd3:    e.result = XLEN'(a < b);
        3'd4:    e.result = a ^ b;
        3'd5:    e.result = f7[5] ? $unsigned(sa >>> sh) : a >> sh;
        3'd6:    e.result = a | b;
        default: e.result = a & b;
      endcase
    end
    e.taken   = e.taken & legal;
    e.we      = legal && opc != `ALU_OPC_BRANCH && e.rd != 5'd0;
    e.illegal = !legal;
    return e;
  endfunction

  task automatic check_value(input string what, input logic [31:0] ins,
                             input logic [XLEN-1:0] got, input logic [XLEN-1:0] want);
    if (got !== want) begin
      $display("ERR %0t: %s mismatch for instr %h, got %h expected %h",
               $time, what, ins, got, want);
      errors = errors + 1;
    end
  endtask

  task automatic compare(input expect_t want);
    checked = checked + 1;
    if (!out_valid) begin
      $display("instr %h did not come out at cycle %0d", want.instr, want.due);
      errors = errors + 1;
    end else if (cycle != want.due) begin
      $display("instr %h came out at cycle %0d instead of %0d", want.instr, cycle, want.due);
      errors = errors + 1;
    end else begin
      check_value("rd", want.instr, XLEN'(rd), XLEN'(want.rd));
      check_value("write_en", want.instr, XLEN'(write_en), XLEN'(want.we));
      check_value("branch_taken", want.instr, XLEN'(branch_taken), XLEN'(want.taken));
      check_value("illegal", want.instr, XLEN'(illegal), XLEN'(want.illegal));
      // result and flags are undefined for illegal encodings
      if (!want.illegal) begin
        check_value("result", want.instr, result, want.result);
        check_value("flags", want.instr, XLEN'(flags), XLEN'(want.flags));
      end
    end
  endtask

  always @(posedge clock or negedge arst_n) begin : sample
    expect_t want;
    if (!arst_n) begin
      exp_q.delete();
      cycle   = 0;
      checked = 0;
      errors  = 0;
      pending = 0;
    end else begin
      cycle = cycle + 1;
      if (out_valid && exp_q.size() == 0) begin
        $display("out_valid seen at %0t with no instruction in flight", $time);
        errors = errors + 1;
      end else if (out_valid || (exp_q.size() != 0 && exp_q[0].due == cycle)) begin
        want = exp_q.pop_front();
        compare(want);
      end
      if (in_valid) begin
        want     = predict(instr, rs1_data, rs2_data);
        // result stage registers two edges later, visible on the third
        want.due = cycle + 3;
        exp_q.push_back(want);
      end
      pending = exp_q.size();
    end
  end

endmodule

//--- bench/alu_tb.sv
`timescale 1ns/1ps
`include "alu_config.svh"

module alu_tb;
  import alu_pkg::*;

  localparam int XLEN     = `ALU_XLEN;
  localparam int PER_TEST = 400;
  localparam int TESTS    = 4;

  logic            clock;
  logic            arst_n;
  logic            in_valid;
  logic [31:0]     instr;
  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;
  logic            out_valid;
  logic [XLEN-1:0] result;
  logic [4:0]      rd;
  logic            write_en;
  alu_flags_t      flags;
  logic            branch_taken;
  logic            illegal;
  int              checked;
  int              errors;
  int              pending;
  int              prop_fails;

  always #2 clock = ~clock;

  alu_top alu_top_i (.*);

  alu_checker checker_i (.*);

  // corner values show up often
  function automatic logic [XLEN-1:0] pick_operand();
    case ($urandom_range(0, 6))
      0:       return '0;
      1:       return '1;
      2:       return {1'b1, {(XLEN-1){1'b0}}};
      3:       return XLEN'($urandom_range(0, 40));
      default: return XLEN'($urandom());
    endcase
  endfunction

  // kind 0 op, 1 op-imm, 2 m group, 3 branch, 4 junk
  function automatic logic [31:0] make_instr(input int kind);
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [6:0]  opc;
    logic [4:0]  rd_f;
    logic [31:0] bits;
    f3   = 3'($urandom_range(0, 7));
    f7   = 7'h00;
    opc  = `ALU_OPC_OP;
    rd_f = ($urandom_range(0, 7) == 0) ? 5'd0 : 5'($urandom_range(1, 31));
    bits = $urandom();
    case (kind)
      0: f7 = ((f3 == 3'd0 || f3 == 3'd5) && $urandom_range(0, 1) == 1) ? 7'h20 : 7'h00;
      1: begin
        opc = `ALU_OPC_OP_IMM;
        f7  = bits[31:25];
        if (f3 == 3'd1) begin
          f7 = 7'h00;
        end else if (f3 == 3'd5) begin
          f7 = ($urandom_range(0, 1) == 1) ? 7'h20 : 7'h00;
        end
      end
      2: f7 = 7'h01;
      3: begin
        opc = `ALU_OPC_BRANCH;
        f7  = bits[31:25];
        while (f3 == 3'd2 || f3 == 3'd3) begin
          f3 = 3'($urandom_range(0, 7));
        end
      end
      default: begin
        case ($urandom_range(0, 2))
          0: begin
            do begin
              opc = 7'($urandom());
            end while (opc == `ALU_OPC_OP || opc == `ALU_OPC_OP_IMM || opc == `ALU_OPC_BRANCH);
          end
          1: f7 = {1'b1, 6'($urandom())};
          default: begin
            opc = `ALU_OPC_BRANCH;
            f3  = {2'b01, 1'($urandom())};
          end
        endcase
      end
    endcase
    return {f7, bits[24:15], f3, rd_f, opc};
  endfunction

  task automatic run_test(input string name, input int lo, input int hi);
    int c0;
    int e0;
    int gap;
    c0 = checked;
    e0 = errors;
    for (int i = 0; i < PER_TEST; i++) begin
      @(posedge clock);
      in_valid <= 1'b1;
      instr    <= make_instr($urandom_range(lo, hi));
      rs1_data <= pick_operand();
      rs2_data <= pick_operand();
      if ($urandom_range(0, 3) == 0) begin
        gap = $urandom_range(1, 4);
        repeat (gap) begin
          @(posedge clock);
          in_valid <= 1'b0;
          instr    <= $urandom();
        end
      end
    end
    @(posedge clock);
    in_valid <= 1'b0;
    // let the pipeline drain
    do begin
      @(negedge clock);
    end while (pending != 0);
    $display("test %s: %0d checked, %0d errors", name, checked - c0, errors - e0);
  endtask

  initial begin
    clock    = 1'b0;
    arst_n   = 1'b0;
    in_valid = 1'b0;
    instr    = '0;
    rs1_data = '0;
    rs2_data = '0;
    void'($urandom(94));
    repeat (5) @(posedge clock);
    arst_n <= 1'b1;
    run_test("base ops", 0, 1);
    run_test("m extension", 2, 2);
    run_test("branches", 3, 3);
    run_test("mixed with junk", 0, 4);
    prop_fails = alu_top_i.alu_properties_i.failures;
    $display("%0d tests, %0d checked, %0d errors, %0d assertion failures",
             TESTS, checked, errors, prop_fails);
    if (errors == 0 && prop_fails == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // at most 5 cycles per instruction plus drain time
  initial begin
    repeat (TESTS * PER_TEST * 8 + 100) @(posedge clock);
    $display("the run timed out before all tests finished");
    $display("Finished with errors");
    $finish;
  end

endmodule

//--- compile.f
+incdir+include
hw/alu_pkg.sv
hw/prefix_adder.sv
hw/barrel_shifter.sv
hw/alu_decoder.sv
hw/alu_execute.sv
hw/alu_result.sv
hw/alu_top.sv
bench/alu_properties.sv
bench/alu_checker.sv
bench/alu_tb.sv
